// File: spmd_system.f
source/spmd_pkg.sv
source/shared_mem.sv
source/mem_arbiter.sv
source/host_loader.sv
source/spmd_tile.sv
source/finish_monitor.sv
source/spmd_system.sv
tb/spmd_system_tb.sv

// File: Bender.yml
package:
  name: spmd_system

sources:
  - files:
      - source/spmd_pkg.sv
      - source/shared_mem.sv
      - source/mem_arbiter.sv
      - source/host_loader.sv
      - source/spmd_tile.sv
      - source/finish_monitor.sv
      - source/spmd_system.sv
  - target: test
    files:
      - tb/spmd_system_tb.sv

// File: tb/spmd_system_tb.sv
`default_nettype none

module spmd_system_tb
  import spmd_pkg::*;
  ;

  timeunit 1ns;
  timeprecision 1ps;

  // whole run is about 2000 cycles of traffic, the limit leaves a wide margin
  localparam int timeout_cycles_lp = 20000;

  logic                     clk_i;
  logic                     rst_i;
  logic                     cmd_v_i;
  host_op_e                 cmd_op_i;
  logic [addr_width_lp-1:0] cmd_addr_i;
  logic [data_width_lp-1:0] cmd_data_i;
  logic                     busy_o;
  logic                     rd_v_o;
  logic [data_width_lp-1:0] rd_data_o;
  logic                     finish_o;
  logic [ctr_width_lp-1:0]  cycle_count_o;

  logic [data_width_lp-1:0] model [mem_words_lp];  // expected memory contents
  int                       seed;
  int                       errors;
  int                       cycles;

  spmd_system dut
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.cmd_v_i(cmd_v_i)
    ,.cmd_op_i(cmd_op_i)
    ,.cmd_addr_i(cmd_addr_i)
    ,.cmd_data_i(cmd_data_i)
    ,.busy_o(busy_o)
    ,.rd_v_o(rd_v_o)
    ,.rd_data_o(rd_data_o)
    ,.finish_o(finish_o)
    ,.cycle_count_o(cycle_count_o)
    );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= timeout_cycles_lp) begin
      $display("run timed out after %0d cycles without finishing the tests", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  // strobe one command for a cycle, once the loader is free
  task automatic send_cmd(input host_op_e op, input logic [7:0] addr, input logic [31:0] data);
    while (busy_o) @(negedge clk_i);
    cmd_v_i    = 1'b1;
    cmd_op_i   = op;
    cmd_addr_i = addr;
    cmd_data_i = data;
    @(negedge clk_i);
    cmd_v_i  = 1'b0;
    cmd_op_i = OP_NOP;
  endtask

  task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
    send_cmd(OP_WRITE, addr, data);
    model[addr] = data;
  endtask

  task automatic host_read(input logic [7:0] addr, output logic [31:0] data);
    send_cmd(OP_READ, addr, '0);
    while (!rd_v_o) @(negedge clk_i);
    data = rd_data_o;
    @(negedge clk_i);
    check_eq("rd_v_o", 32'd0, 32'(rd_v_o));  // one-cycle pulse
  endtask

  function automatic logic [31:0] slice_sum(input int t, input int n);
    logic [31:0] acc;
    acc = '0;
    for (int i = 0; i < n; i++) begin
      acc += model[slice_base_lp + t * slice_stride_lp + i];
    end
    return acc;
  endfunction

  task automatic fill_slices();
    for (int t = 0; t < num_tiles_lp; t++) begin
      for (int i = 0; i < slice_stride_lp; i++) begin
        host_write(8'(slice_base_lp + t * slice_stride_lp + i), $random(seed));
      end
    end
  endtask

  task automatic check_idle_after_reset();
    check_eq("busy_o", 32'd0, 32'(busy_o));
    check_eq("rd_v_o", 32'd0, 32'(rd_v_o));
    check_eq("finish_o", 32'd0, 32'(finish_o));
  endtask

  task automatic write_read_random();
    logic [7:0]  addrs [12];
    logic [31:0] got;
    for (int i = 0; i < 12; i++) begin
      addrs[i] = 8'($random(seed));
      host_write(addrs[i], $random(seed));
    end
    for (int i = 0; i < 12; i++) begin
      host_read(addrs[i], got);
      check_eq($sformatf("rd_data_o[%0d]", addrs[i]), model[addrs[i]], got);
    end
  endtask

  // start a kernel of n words and check results and cycle count
  task automatic run_kernel(input int n);
    logic [31:0] got;
    logic [31:0] count;
    send_cmd(OP_START, '0, 32'(n));
    @(negedge clk_i);  // older finish clears here
    while (!finish_o) begin
      if (!busy_o) begin
        $display("busy_o dropped during kernel run at time %0t", $time);
        errors++;
      end
      @(negedge clk_i);
    end
    check_eq("busy_o", 32'd1, 32'(busy_o));
    count = cycle_count_o;
    if (count == 0 || count < 4 * (n + 1)) begin
      $display("cycle count %0d below the bus minimum %0d for N=%0d", count, 4 * (n + 1), n);
      errors++;
    end
    repeat (4) @(negedge clk_i);
    check_eq("cycle_count_o", count, cycle_count_o);
    for (int t = 0; t < num_tiles_lp; t++) begin
      model[result_base_lp + t] = slice_sum(t, n);
      host_read(8'(result_base_lp + t), got);
      check_eq($sformatf("result[%0d] N=%0d", t, n), model[result_base_lp + t], got);
    end
  endtask

  initial begin
    seed       = 73;
    errors     = 0;
    cycles     = 0;
    rst_i      = 1'b1;
    cmd_v_i    = 1'b0;
    cmd_op_i   = OP_NOP;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    check_idle_after_reset();
    write_read_random();
    fill_slices();
    run_kernel(8);
    fill_slices();
    run_kernel(1);
    fill_slices();
    run_kernel(31);

    $display("tests done with %0d errors", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/spmd_system.sv
`default_nettype none

module spmd_system
  import spmd_pkg::*;
  (input  wire logic                     clk_i
  ,input  wire logic                     rst_i
  ,input  wire logic                     cmd_v_i
  ,input  wire host_op_e                 cmd_op_i
  ,input  wire logic [addr_width_lp-1:0] cmd_addr_i
  ,input  wire logic [data_width_lp-1:0] cmd_data_i
  ,output logic                          busy_o
  ,output logic                          rd_v_o
  ,output logic      [data_width_lp-1:0] rd_data_o
  ,output logic                          finish_o
  ,output logic      [ctr_width_lp-1:0]  cycle_count_o
  );

  // bus, one slot per master
  logic [num_masters_lp-1:0]                    req_lo;
  logic [num_masters_lp-1:0]                    we_lo;
  logic [num_masters_lp-1:0][addr_width_lp-1:0] addr_lo;
  logic [num_masters_lp-1:0][data_width_lp-1:0] wdata_lo;
  logic [num_masters_lp-1:0]                    gnt_lo;
  logic [data_width_lp-1:0]                     rdata_lo;

  logic                    start_lo;
  logic [len_width_lp-1:0] len_lo;
  logic [num_tiles_lp-1:0] done_lo;

  host_loader loader
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.cmd_v_i(cmd_v_i)
    ,.cmd_op_i(cmd_op_i)
    ,.cmd_addr_i(cmd_addr_i)
    ,.cmd_data_i(cmd_data_i)
    ,.busy_o(busy_o)
    ,.rd_v_o(rd_v_o)
    ,.rd_data_o(rd_data_o)
    ,.req_o(req_lo[loader_id_lp])
    ,.we_o(we_lo[loader_id_lp])
    ,.addr_o(addr_lo[loader_id_lp])
    ,.wdata_o(wdata_lo[loader_id_lp])
    ,.gnt_i(gnt_lo[loader_id_lp])
    ,.rdata_i(rdata_lo)
    ,.start_o(start_lo)
    ,.len_o(len_lo)
    ,.finish_i(finish_o)
    );

  for (genvar i = 0; i < num_tiles_lp; i++) begin : tile
    spmd_tile #(.tile_id_p(i)) t
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.start_i(start_lo)
      ,.len_i(len_lo)
      ,.req_o(req_lo[i])
      ,.we_o(we_lo[i])
      ,.addr_o(addr_lo[i])
      ,.wdata_o(wdata_lo[i])
      ,.gnt_i(gnt_lo[i])
      ,.rdata_i(rdata_lo)
      ,.done_o(done_lo[i])
      );
  end

  mem_arbiter arb
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.req_i(req_lo)
    ,.we_i(we_lo)
    ,.addr_i(addr_lo)
    ,.wdata_i(wdata_lo)
    ,.gnt_o(gnt_lo)
    ,.rdata_o(rdata_lo)
    );

  finish_monitor monitor
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.start_i(start_lo)
    ,.done_i(done_lo)
    ,.finish_o(finish_o)
    ,.cycle_count_o(cycle_count_o)
    );

endmodule

`default_nettype wire

// File: source/finish_monitor.sv
`default_nettype none

module finish_monitor
  import spmd_pkg::*;
  (input  wire logic                    clk_i
  ,input  wire logic                    rst_i
  ,input  wire logic                    start_i
  ,input  wire logic [num_tiles_lp-1:0] done_i
  ,output logic                         finish_o
  ,output logic      [ctr_width_lp-1:0] cycle_count_o
  );

  logic                    run_r;
  logic                    finish_r;
  logic [ctr_width_lp-1:0] ctr_r;
  logic                    all_done;

  assign all_done = &done_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_r    <= 1'b0;
      finish_r <= 1'b0;
      ctr_r    <= '0;
    end else if (start_i) begin
      run_r    <= 1'b1;
      finish_r <= 1'b0;
      ctr_r    <= '0;
    end else if (run_r) begin
      if (all_done) begin
        run_r    <= 1'b0;
        finish_r <= 1'b1;   // held until next start
      end else begin
        ctr_r <= ctr_r + ctr_width_lp'(1);
      end
    end
  end

  assign finish_o      = finish_r;
  assign cycle_count_o = ctr_r;

endmodule

`default_nettype wire

// File: source/spmd_tile.sv
`default_nettype none

module spmd_tile
  import spmd_pkg::*;
  #(parameter int tile_id_p = 0)
  (input  wire logic                     clk_i
  ,input  wire logic                     rst_i
  ,input  wire logic                     start_i
  ,input  wire logic [len_width_lp-1:0]  len_i
  ,output logic                          req_o
  ,output logic                          we_o
  ,output logic      [addr_width_lp-1:0] addr_o
  ,output logic      [data_width_lp-1:0] wdata_o
  ,input  wire logic                     gnt_i
  ,input  wire logic [data_width_lp-1:0] rdata_i
  ,output logic                          done_o
  );

  localparam logic [addr_width_lp-1:0] slice_addr_lp =
    addr_width_lp'(slice_base_lp + tile_id_p * slice_stride_lp);
  localparam logic [addr_width_lp-1:0] result_addr_lp =
    addr_width_lp'(result_base_lp + tile_id_p);

  tile_state_e              state_r;
  logic [len_width_lp-1:0]  len_r;
  logic [len_width_lp-1:0]  count_r;   // words summed so far
  logic [data_width_lp-1:0] sum_r;
  logic                     last_rd;

  assign last_rd = (count_r == len_r - len_width_lp'(1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= TS_IDLE;
    end else begin
      case (state_r)
        TS_IDLE, TS_DONE: begin
          if (start_i) begin
            state_r <= TS_REQ;
          end
        end
        TS_REQ: begin
          if (gnt_i) begin
            state_r <= TS_WAIT;
          end
        end
        TS_WAIT: state_r <= last_rd ? TS_WRITE : TS_REQ;
        TS_WRITE: begin
          if (gnt_i) begin
            state_r <= TS_DONE;
          end
        end
        default: state_r <= TS_IDLE;
      endcase
    end
  end

  // accumulator, restarted by each start
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      len_r   <= len_i;
      count_r <= '0;
      sum_r   <= '0;
    end else if (state_r == TS_WAIT) begin
      sum_r   <= sum_r + rdata_i;
      count_r <= count_r + len_width_lp'(1);
    end
  end

  assign req_o   = (state_r == TS_REQ) || (state_r == TS_WRITE);
  assign we_o    = (state_r == TS_WRITE);
  assign addr_o  = we_o ? result_addr_lp : slice_addr_lp + addr_width_lp'(count_r);
  assign wdata_o = sum_r;
  assign done_o  = (state_r == TS_DONE);

  // loader only starts a kernel once every tile is back to rest
  start_at_rest_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    start_i |-> (state_r inside {TS_IDLE, TS_DONE})
  ) else $error("spmd_tile %0d: start while kernel running", tile_id_p);

endmodule

`default_nettype wire

// File: source/host_loader.sv
`default_nettype none

module host_loader
  import spmd_pkg::*;
  (input  wire logic                     clk_i
  ,input  wire logic                     rst_i
  // host side
  ,input  wire logic                     cmd_v_i
  ,input  wire host_op_e                 cmd_op_i
  ,input  wire logic [addr_width_lp-1:0] cmd_addr_i
  ,input  wire logic [data_width_lp-1:0] cmd_data_i
  ,output logic                          busy_o
  ,output logic                          rd_v_o
  ,output logic      [data_width_lp-1:0] rd_data_o
  // bus master
  ,output logic                          req_o
  ,output logic                          we_o
  ,output logic      [addr_width_lp-1:0] addr_o
  ,output logic      [data_width_lp-1:0] wdata_o
  ,input  wire logic                     gnt_i
  ,input  wire logic [data_width_lp-1:0] rdata_i
  // kernel control
  ,output logic                          start_o
  ,output logic      [len_width_lp-1:0]  len_o
  ,input  wire logic                     finish_i
  );

  logic                     req_r;
  logic                     run_r;     // kernel in flight
  logic                     start_r;
  logic                     rd_v_r;
  logic                     we_r;
  logic [addr_width_lp-1:0] addr_r;
  logic [data_width_lp-1:0] wdata_r;
  logic [len_width_lp-1:0]  len_r;
  logic                     cmd_take;

  assign cmd_take = cmd_v_i && !busy_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_r   <= 1'b0;
      run_r   <= 1'b0;
      start_r <= 1'b0;
      rd_v_r  <= 1'b0;
    end else begin
      start_r <= 1'b0;
      rd_v_r  <= req_r && gnt_i && !we_r;  // data lands with this pulse
      if (cmd_take) begin
        case (cmd_op_i)
          OP_WRITE, OP_READ: req_r <= 1'b1;
          OP_START: begin
            run_r   <= 1'b1;
            start_r <= 1'b1;
          end
          default: ;
        endcase
      end else if (req_r && gnt_i) begin
        req_r <= 1'b0;
      end else if (run_r && finish_i && !start_r) begin
        // finish from an older run is still high during the start pulse
        run_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_take) begin
      we_r    <= (cmd_op_i == OP_WRITE);
      addr_r  <= cmd_addr_i;
      wdata_r <= cmd_data_i;
      if (cmd_op_i == OP_START) begin
        len_r <= cmd_data_i[len_width_lp-1:0];
      end
    end
  end

  assign busy_o    = req_r | run_r;
  assign rd_v_o    = rd_v_r;
  assign rd_data_o = rdata_i;
  assign req_o     = req_r;
  assign we_o      = we_r;
  assign addr_o    = addr_r;
  assign wdata_o   = wdata_r;
  assign start_o   = start_r;
  assign len_o     = len_r;

  // host must wait out a running kernel as well as a bus access
  no_cmd_when_busy_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    cmd_v_i |-> !busy_o
  ) else $error("host_loader: command strobed while busy");

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`default_nettype none

module mem_arbiter
  import spmd_pkg::*;
  (input  wire logic                                         clk_i
  ,input  wire logic                                         rst_i
  ,input  wire logic [num_masters_lp-1:0]                    req_i
  ,input  wire logic [num_masters_lp-1:0]                    we_i
  ,input  wire logic [num_masters_lp-1:0][addr_width_lp-1:0] addr_i
  ,input  wire logic [num_masters_lp-1:0][data_width_lp-1:0] wdata_i
  ,output logic      [num_masters_lp-1:0]                    gnt_o
  ,output logic      [data_width_lp-1:0]                     rdata_o
  );

  logic [master_id_width_lp-1:0] last_r;
  logic [master_id_width_lp-1:0] win_id;
  logic                          win_v;

  // search starts one past the last winner
  always_comb begin
    int cand;
    gnt_o  = '0;
    win_id = last_r;
    win_v  = 1'b0;
    cand   = 0;
    for (int i = 1; i <= num_masters_lp; i++) begin
      cand = (int'(last_r) + i) % num_masters_lp;
      if (!win_v && req_i[cand]) begin
        win_v  = 1'b1;
        win_id = master_id_width_lp'(cand);
      end
    end
    if (win_v) begin
      gnt_o[win_id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_r <= master_id_width_lp'(num_masters_lp - 1);  // master 0 first
    end else if (win_v) begin
      last_r <= win_id;
    end
  end

  shared_mem mem
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.we_i(we_i[win_id])
    ,.addr_i(addr_i[win_id])
    ,.wdata_i(wdata_i[win_id])
    ,.en_i(win_v)
    ,.rdata_o(rdata_o)
    );

  // a granted master lets go of req the next cycle
  gnt_then_drop_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    win_v |=> (req_i & $past(gnt_o)) == '0
  ) else $error("mem_arbiter: master kept req after its grant");

endmodule

`default_nettype wire

// File: source/shared_mem.sv
`default_nettype none

module shared_mem
  import spmd_pkg::*;
  (input  wire logic                     clk_i
  ,input  wire logic                     rst_i
  ,input  wire logic                     we_i
  ,input  wire logic [addr_width_lp-1:0] addr_i
  ,input  wire logic [data_width_lp-1:0] wdata_i
  ,input  wire logic                     en_i
  ,output logic      [data_width_lp-1:0] rdata_o
  );

  logic [data_width_lp-1:0] mem_r [mem_words_lp];
  logic [data_width_lp-1:0] rdata_r;

  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      mem_r[addr_i] <= wdata_i;
    end
  end

  // read word shows up the cycle after the access
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_r <= '0;
    end else if (en_i && !we_i) begin
      rdata_r <= mem_r[addr_i];
    end
  end

  assign rdata_o = rdata_r;

  // a granted master must present a real address
  addr_known_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    en_i |-> !$isunknown(addr_i)
  ) else $error("shared_mem: unknown address on an enabled access");

endmodule

`default_nettype wire

// File: source/spmd_pkg.sv
`default_nettype none

package spmd_pkg;

  // memory geometry
  localparam int data_width_lp = 32;
  localparam int addr_width_lp = 8;
  localparam int mem_words_lp  = 1 << addr_width_lp;

  localparam int num_tiles_lp       = 4;
  localparam int num_masters_lp     = 5;                 // tiles plus loader
  localparam int loader_id_lp       = num_masters_lp - 1;
  localparam int master_id_width_lp = $clog2(num_masters_lp);

  // memory map of the kernel
  localparam int slice_base_lp   = 0;
  localparam int slice_stride_lp = 32;
  localparam int result_base_lp  = 240;   // tile t writes at +t

  localparam int len_width_lp = 5;
  localparam int ctr_width_lp = 32;

  typedef enum logic [1:0] {
    OP_WRITE = 2'b00,
    OP_READ  = 2'b01,
    OP_START = 2'b10,
    OP_NOP   = 2'b11
  } host_op_e;

  typedef enum logic [2:0] {
    TS_IDLE,
    TS_REQ,
    TS_WAIT,   // read word arrives here
    TS_WRITE,
    TS_DONE
  } tile_state_e;

endpackage

`default_nettype wire
